// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
		--top-module m26_rx_tb -f verilog.f -Mdir obj_dir -o m26_rx_sim
	./obj_dir/m26_rx_sim | tee sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== rtl/m26_bus_pkg.sv ====
package m26_bus_pkg;

    // register map of the 8-bit control bus.
    typedef enum logic [3:0] {
        // write is a soft reset, read gives the version.
        REG_CTRL   = 4'd0,
        // bit 0 enables the receiver.
        REG_ENABLE = 4'd2,
        // saturating lost-word count, read only.
        REG_LOST   = 4'd3
    } m26_reg_addr_e;

    // bus data width.
    typedef logic [7:0] m26_bus_data_t;

endpackage

// ==== rtl/m26_frame_pkg.sv ====
package m26_frame_pkg;

    // position inside one frame of a data line.
    typedef enum logic [2:0] {
        IDLE     = 3'd0,
        HEADER   = 3'd1,
        FRAME_HI = 3'd2,
        FRAME_LO = 3'd3,
        LENGTH   = 3'd4,
        DATA     = 3'd5,
        TRAILER  = 3'd6
    } m26_ch_state_e;

    // one deserialized word, MSB arrives first.
    typedef logic [15:0] m26_word_t;

    // tagged word as stored in the FIFO and sent to the consumer.
    typedef struct packed {
        logic [6:0] plane_id;
        // unused, always zero.
        logic [6:0] zero;
        // 0 for data line 0, 1 for data line 1.
        logic       ch;
        // set on the header word only.
        logic       frame_start;
        m26_word_t  word;
    } m26_out_word_t;

endpackage

// ==== rtl/m26_rx_cfg.svh ====
`ifndef M26_RX_CFG_SVH
`define M26_RX_CFG_SVH

// version returned on a read of the control register.
`define M26_VERSION 8'h01

// plane identifier, top seven bits of every output word.
`define M26_PLANE_ID 7'h05

// log2 of the output FIFO depth.
`define M26_FIFO_AW 4

// largest length field still accepted.
`define M26_MAX_LEN 8

// channel 1 lags channel 0 by this many cycles.
`define M26_CH1_SKEW 4

`endif

// ==== rtl/m26_rx_ch.sv ====
`timescale 1ns/1ns
`include "m26_rx_cfg.svh"

module m26_rx_ch (
    input  logic                      CLK_RX,
    input  logic                      RST,
    input  logic                      mkd,
    input  logic                      data,
    output logic                      word_wr,
    output m26_frame_pkg::m26_word_t  word,
    output logic                      frame_start
);

    localparam int LEN_W = $clog2(`M26_MAX_LEN + 1);

    m26_frame_pkg::m26_ch_state_e state;
    logic [2:0]                   mkd_run;
    logic [3:0]                   bit_cnt;
    logic [15:0]                  sreg;
    logic [LEN_W-1:0]             data_left;
    logic                         mkd_start;
    logic                         word_done;
    m26_frame_pkg::m26_word_t     word_next;

    // fourth consecutive marker sample starts a frame.
    assign mkd_start = mkd && (mkd_run == 3'd3);

    // last bit of a word sampled this cycle.
    assign word_done = (state != m26_frame_pkg::IDLE) && (bit_cnt == 4'd15);
    assign word_next = {sreg[14:0], data};

    // shift register holds the finished word in the strobe cycle.
    assign word = sreg;

    always_ff @(posedge CLK_RX) begin
        sreg <= word_next;
    end

    // marker run length, saturating.
    always_ff @(posedge CLK_RX) begin
        if (RST) begin
            mkd_run <= '0;
        end else if (!mkd) begin
            mkd_run <= '0;
        end else if (mkd_run != 3'd7) begin
            mkd_run <= mkd_run + 3'd1;
        end
    end

    always_ff @(posedge CLK_RX) begin
        if (RST) begin
            bit_cnt <= '0;
        end else if (state == m26_frame_pkg::IDLE) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 4'd1;
        end
    end

    // frame FSM.
    always_ff @(posedge CLK_RX) begin
        if (RST) begin
            state     <= m26_frame_pkg::IDLE;
            data_left <= '0;
        end else begin
            case (state)
                m26_frame_pkg::IDLE: begin
                    if (mkd_start) begin
                        state <= m26_frame_pkg::HEADER;
                    end
                end
                m26_frame_pkg::HEADER: begin
                    if (word_done) begin
                        state <= m26_frame_pkg::FRAME_HI;
                    end
                end
                m26_frame_pkg::FRAME_HI: begin
                    if (word_done) begin
                        state <= m26_frame_pkg::FRAME_LO;
                    end
                end
                m26_frame_pkg::FRAME_LO: begin
                    if (word_done) begin
                        state <= m26_frame_pkg::LENGTH;
                    end
                end
                m26_frame_pkg::LENGTH: begin
                    if (word_done) begin
                        // oversized frames are abandoned after the length word.
                        if (word_next > `M26_MAX_LEN) begin
                            state <= m26_frame_pkg::IDLE;
                        end else if (word_next == '0) begin
                            state <= m26_frame_pkg::TRAILER;
                        end else begin
                            state     <= m26_frame_pkg::DATA;
                            data_left <= word_next[LEN_W-1:0];
                        end
                    end
                end
                m26_frame_pkg::DATA: begin
                    if (word_done) begin
                        data_left <= data_left - LEN_W'(1);
                        if (data_left == LEN_W'(1)) begin
                            state <= m26_frame_pkg::TRAILER;
                        end
                    end
                end
                m26_frame_pkg::TRAILER: begin
                    if (word_done) begin
                        state <= m26_frame_pkg::IDLE;
                    end
                end
                default: begin
                    state <= m26_frame_pkg::IDLE;
                end
            endcase
        end
    end

    // strobe one cycle after the last bit.
    always_ff @(posedge CLK_RX) begin
        if (RST) begin
            word_wr     <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            word_wr     <= word_done;
            frame_start <= word_done && (state == m26_frame_pkg::HEADER);
        end
    end

endmodule

// ==== rtl/m26_rx_core.sv ====
`timescale 1ns/1ns
`include "m26_rx_cfg.svh"

module m26_rx_core (
    input  logic                          CLK_RX,
    input  logic                          RST,
    input  logic                          mkd_rx,
    input  logic [1:0]                    data_rx,
    input  m26_bus_pkg::m26_reg_addr_e    bus_addr,
    input  logic                          bus_wr,
    input  logic                          bus_rd,
    input  m26_bus_pkg::m26_bus_data_t    bus_wdata,
    output m26_bus_pkg::m26_bus_data_t    bus_rdata,
    output logic                          out_valid,
    output m26_frame_pkg::m26_out_word_t  out_data,
    input  logic                          out_ready,
    output logic                          lost_error
);

    localparam int SKEW = `M26_CH1_SKEW;

    logic                          enable;
    logic                          soft_rst;
    logic                          rst_int;
    logic [SKEW:0]                 mkd_dly;
    logic                          data0_q;
    logic [SKEW:0]                 data1_dly;
    logic [1:0]                    word_wr;
    logic [1:0]                    frame_start;
    m26_frame_pkg::m26_word_t      word [2];
    logic                          fifo_wr;
    logic                          fifo_full;
    m26_frame_pkg::m26_out_word_t  fifo_wdata;
    m26_bus_pkg::m26_bus_data_t    lost_cnt;

    assign rst_int = RST || soft_rst;

    m26_rx_regs u_regs (
        .CLK_RX    (CLK_RX),
        .RST       (RST),
        .bus_addr  (bus_addr),
        .bus_wr    (bus_wr),
        .bus_rd    (bus_rd),
        .bus_wdata (bus_wdata),
        .bus_rdata (bus_rdata),
        .lost_cnt  (lost_cnt),
        .enable    (enable),
        .soft_rst  (soft_rst)
    );

    // input registers; channel 1 sees its lines SKEW cycles later.
    always_ff @(posedge CLK_RX) begin
        if (rst_int) begin
            mkd_dly <= '0;
        end else begin
            mkd_dly <= {mkd_dly[SKEW-1:0], mkd_rx};
        end
    end

    always_ff @(posedge CLK_RX) begin
        data0_q   <= data_rx[0];
        data1_dly <= {data1_dly[SKEW-1:0], data_rx[1]};
    end

    m26_rx_ch u_ch0 (
        .CLK_RX      (CLK_RX),
        .RST         (rst_int),
        .mkd         (mkd_dly[0]),
        .data        (data0_q),
        .word_wr     (word_wr[0]),
        .word        (word[0]),
        .frame_start (frame_start[0])
    );

    m26_rx_ch u_ch1 (
        .CLK_RX      (CLK_RX),
        .RST         (rst_int),
        .mkd         (mkd_dly[SKEW]),
        .data        (data1_dly[SKEW]),
        .word_wr     (word_wr[1]),
        .word        (word[1]),
        .frame_start (frame_start[1])
    );

    // merge and tag; the strobes never coincide.
    always_ff @(posedge CLK_RX) begin
        if (rst_int) begin
            fifo_wr <= 1'b0;
        end else begin
            fifo_wr <= enable && (|word_wr);
        end
    end

    always_ff @(posedge CLK_RX) begin
        if (|word_wr) begin
            fifo_wdata.plane_id    <= `M26_PLANE_ID;
            fifo_wdata.zero        <= '0;
            fifo_wdata.ch          <= word_wr[1];
            fifo_wdata.frame_start <= word_wr[0] ? frame_start[0] : frame_start[1];
            fifo_wdata.word        <= word_wr[0] ? word[0] : word[1];
        end
    end

    // words dropped on a full FIFO, saturating at 255.
    always_ff @(posedge CLK_RX) begin
        if (rst_int) begin
            lost_cnt <= '0;
        end else if (fifo_wr && fifo_full && (lost_cnt != 8'hff)) begin
            lost_cnt <= lost_cnt + 8'd1;
        end
    end

    assign lost_error = (lost_cnt != '0);

    m26_rx_fifo #(
        .DATA_W (32),
        .ADDR_W (`M26_FIFO_AW)
    ) u_fifo (
        .CLK_RX   (CLK_RX),
        .RST      (rst_int),
        .wr       (fifo_wr),
        .wdata    (fifo_wdata),
        .full     (fifo_full),
        .rd_valid (out_valid),
        .rd_ready (out_ready),
        .rd_data  (out_data)
    );

endmodule

// ==== rtl/m26_rx_fifo.sv ====
`timescale 1ns/1ns

module m26_rx_fifo #(
    parameter int DATA_W = 32,
    parameter int ADDR_W = 4
) (
    input  logic              CLK_RX,
    input  logic              RST,
    input  logic              wr,
    input  logic [DATA_W-1:0] wdata,
    output logic              full,
    output logic              rd_valid,
    input  logic              rd_ready,
    output logic [DATA_W-1:0] rd_data
);

    localparam int DEPTH = 1 << ADDR_W;

    logic [DATA_W-1:0] mem [DEPTH];
    logic [ADDR_W:0]   wr_ptr;
    logic [ADDR_W:0]   rd_ptr;
    logic              do_wr;
    logic              do_rd;

    // pointers equal except the wrap bit means full.
    assign full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                  (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
    assign rd_valid = (wr_ptr != rd_ptr);
    assign rd_data  = mem[rd_ptr[ADDR_W-1:0]];

    // a write into a full buffer is dropped.
    assign do_wr = wr && !full;
    assign do_rd = rd_valid && rd_ready;

    always_ff @(posedge CLK_RX) begin
        if (do_wr) begin
            mem[wr_ptr[ADDR_W-1:0]] <= wdata;
        end
    end

    always_ff @(posedge CLK_RX) begin
        if (RST) begin
            wr_ptr <= '0;
        end else if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge CLK_RX) begin
        if (RST) begin
            rd_ptr <= '0;
        end else if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

// ==== rtl/m26_rx_regs.sv ====
`timescale 1ns/1ns
`include "m26_rx_cfg.svh"

module m26_rx_regs (
    input  logic                         CLK_RX,
    input  logic                         RST,
    input  m26_bus_pkg::m26_reg_addr_e   bus_addr,
    input  logic                         bus_wr,
    input  logic                         bus_rd,
    input  m26_bus_pkg::m26_bus_data_t   bus_wdata,
    output m26_bus_pkg::m26_bus_data_t   bus_rdata,
    input  m26_bus_pkg::m26_bus_data_t   lost_cnt,
    output logic                         enable,
    output logic                         soft_rst
);

    logic ctrl_wr;
    logic enable_wr;

    assign ctrl_wr   = bus_wr && (bus_addr == m26_bus_pkg::REG_CTRL);
    assign enable_wr = bus_wr && (bus_addr == m26_bus_pkg::REG_ENABLE);

    // one-cycle soft reset pulse.
    always_ff @(posedge CLK_RX) begin
        if (RST) begin
            soft_rst <= 1'b0;
        end else begin
            soft_rst <= ctrl_wr;
        end
    end

    // enable bit, cleared by either reset.
    always_ff @(posedge CLK_RX) begin
        if (RST || ctrl_wr) begin
            enable <= 1'b0;
        end else if (enable_wr) begin
            enable <= bus_wdata[0];
        end
    end

    // readback, held until the next read.
    always_ff @(posedge CLK_RX) begin
        if (bus_rd) begin
            case (bus_addr)
                m26_bus_pkg::REG_CTRL: begin
                    bus_rdata <= m26_bus_pkg::m26_bus_data_t'(`M26_VERSION);
                end
                m26_bus_pkg::REG_ENABLE: begin
                    bus_rdata <= {7'b0, enable};
                end
                m26_bus_pkg::REG_LOST: begin
                    bus_rdata <= lost_cnt;
                end
                default: begin
                    bus_rdata <= '0;
                end
            endcase
        end
    end

endmodule

// ==== sim/m26_rx_tb.sv ====
`timescale 1ns/1ns
`include "m26_rx_cfg.svh"

module m26_rx_tb;

    localparam int TIMEOUT    = 400;
    localparam int QUIET      = 80;
    localparam int FIFO_DEPTH = 1 << `M26_FIFO_AW;

    typedef struct {
        string name;
        bit    en;
        int    len;
        int    ndata;
        bit    hold;
        int    lost;
    } row_t;

    logic                          CLK_RX;
    logic                          RST;
    logic                          mkd_rx;
    logic [1:0]                    data_rx;
    m26_bus_pkg::m26_reg_addr_e    bus_addr;
    logic                          bus_wr;
    logic                          bus_rd;
    m26_bus_pkg::m26_bus_data_t    bus_wdata;
    m26_bus_pkg::m26_bus_data_t    bus_rdata;
    logic                          out_valid;
    m26_frame_pkg::m26_out_word_t  out_data;
    logic                          out_ready;
    logic                          lost_error;

    int                            seed;
    bit                            driving;
    row_t                          rows [6];
    m26_frame_pkg::m26_word_t      s0 [$];
    m26_frame_pkg::m26_word_t      s1 [$];
    m26_frame_pkg::m26_out_word_t  exp_q [$];

    tb_clk_gen u_clk (
        .CLK_RX (CLK_RX),
        .RST    (RST)
    );

    m26_rx_core UUT (
        .CLK_RX     (CLK_RX),
        .RST        (RST),
        .mkd_rx     (mkd_rx),
        .data_rx    (data_rx),
        .bus_addr   (bus_addr),
        .bus_wr     (bus_wr),
        .bus_rd     (bus_rd),
        .bus_wdata  (bus_wdata),
        .bus_rdata  (bus_rdata),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_ready  (out_ready),
        .lost_error (lost_error)
    );

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input m26_frame_pkg::m26_out_word_t exp,
                              input m26_frame_pkg::m26_out_word_t act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_reg(input string name, input m26_bus_pkg::m26_bus_data_t exp,
                             input m26_bus_pkg::m26_bus_data_t act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic bus_write(input m26_bus_pkg::m26_reg_addr_e addr,
                             input m26_bus_pkg::m26_bus_data_t val);
        @(negedge CLK_RX);
        bus_addr  = addr;
        bus_wdata = val;
        bus_wr    = 1'b1;
        @(negedge CLK_RX);
        bus_wr = 1'b0;
    endtask

    // read data is registered and valid one cycle after the strobe.
    task automatic bus_read(input m26_bus_pkg::m26_reg_addr_e addr,
                            output m26_bus_pkg::m26_bus_data_t val);
        @(negedge CLK_RX);
        bus_addr = addr;
        bus_rd   = 1'b1;
        @(negedge CLK_RX);
        bus_rd = 1'b0;
        val    = bus_rdata;
    endtask

    task automatic read_expect(input string name, input m26_bus_pkg::m26_reg_addr_e addr,
                               input m26_bus_pkg::m26_bus_data_t exp);
        m26_bus_pkg::m26_bus_data_t val;
        bus_read(addr, val);
        check_reg(name, exp, val);
    endtask

    task automatic wait_reset();
        int waited;
        waited = 0;
        while (RST !== 1'b0) begin
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("reset was never released");
            end
            @(negedge CLK_RX);
        end
    endtask

    // random frame on both lines plus the expected output order.
    task automatic build_frame(input row_t row);
        m26_frame_pkg::m26_out_word_t ow;
        int n_emit;
        s0.delete();
        s1.delete();
        exp_q.delete();
        for (int ch = 0; ch < 2; ch++) begin
            for (int i = 0; i < row.ndata + 5; i++) begin
                ow.word = m26_frame_pkg::m26_word_t'($random(seed));
                if (i == 3) begin
                    ow.word = m26_frame_pkg::m26_word_t'(row.len);
                end
                if (ch == 0) begin
                    s0.push_back(ow.word);
                end else begin
                    s1.push_back(ow.word);
                end
            end
        end
        // oversized frames end after the length word.
        n_emit = (row.len > `M26_MAX_LEN) ? 4 : row.ndata + 5;
        for (int i = 0; i < n_emit; i++) begin
            for (int ch = 0; ch < 2; ch++) begin
                ow.plane_id    = `M26_PLANE_ID;
                ow.zero        = '0;
                ow.ch          = ch[0];
                ow.frame_start = (i == 0);
                ow.word        = (ch == 0) ? s0[i] : s1[i];
                exp_q.push_back(ow);
            end
        end
        if (!row.en) begin
            exp_q.delete();
        end
        // words beyond the FIFO depth are dropped while blocked.
        while (row.hold && (exp_q.size() > FIFO_DEPTH)) begin
            void'(exp_q.pop_back());
        end
    endtask

    // four marker cycles and then every word MSB first on both lines.
    task automatic drive_frame();
        for (int i = 0; i < 4; i++) begin
            @(negedge CLK_RX);
            mkd_rx  = 1'b1;
            data_rx = 2'b00;
        end
        for (int i = 0; i < s0.size(); i++) begin
            for (int b = 15; b >= 0; b--) begin
                @(negedge CLK_RX);
                mkd_rx  = 1'b0;
                data_rx = {s1[i][b], s0[i][b]};
            end
        end
        @(negedge CLK_RX);
        data_rx = 2'b00;
        repeat (3) @(negedge CLK_RX);
    endtask

    task automatic drain_words(input string name);
        m26_frame_pkg::m26_out_word_t exp;
        int waited;
        while (exp_q.size() > 0) begin
            waited = 0;
            @(negedge CLK_RX);
            out_ready = 1'b1;
            while (!out_valid) begin
                waited++;
                if (waited > TIMEOUT) begin
                    abort_run($sformatf("%s: timed out waiting for out_valid", name));
                end
                @(negedge CLK_RX);
            end
            exp = exp_q.pop_front();
            check_word(name, exp, out_data);
        end
    endtask

    // no word beyond the expected ones while the frame is still being sent.
    task automatic expect_no_words(input string name);
        int waited;
        waited = 0;
        while (driving) begin
            waited++;
            if (waited > TIMEOUT) begin
                abort_run($sformatf("%s: frame driver did not finish", name));
            end
            @(negedge CLK_RX);
            if (out_valid) begin
                abort_run($sformatf("%s: unexpected output word %h", name, out_data));
            end
        end
    endtask

    task automatic expect_quiet(input string name);
        for (int i = 0; i < QUIET; i++) begin
            @(negedge CLK_RX);
            if (out_valid) begin
                abort_run($sformatf("%s: unexpected output word %h", name, out_data));
            end
        end
    endtask

    task automatic wait_lost(input string name, input int exp);
        m26_bus_pkg::m26_bus_data_t val;
        int waited;
        waited = 0;
        bus_read(m26_bus_pkg::REG_LOST, val);
        while (val != m26_bus_pkg::m26_bus_data_t'(exp)) begin
            waited++;
            if (waited > TIMEOUT) begin
                abort_run($sformatf("%s: lost counter never reached %0d", name, exp));
            end
            bus_read(m26_bus_pkg::REG_LOST, val);
        end
    endtask

    task automatic run_row(input row_t row);
        bus_write(m26_bus_pkg::REG_ENABLE, m26_bus_pkg::m26_bus_data_t'(row.en));
        read_expect({row.name, "_enable"}, m26_bus_pkg::REG_ENABLE,
                    m26_bus_pkg::m26_bus_data_t'(row.en));
        build_frame(row);
        if (row.hold) begin
            @(negedge CLK_RX);
            out_ready = 1'b0;
            drive_frame();
            wait_lost(row.name, row.lost);
            drain_words(row.name);
        end else begin
            driving = 1'b1;
            fork
                begin
                    drive_frame();
                    driving = 1'b0;
                end
                begin
                    drain_words(row.name);
                    expect_no_words(row.name);
                end
            join
        end
        expect_quiet(row.name);
        read_expect({row.name, "_lost"}, m26_bus_pkg::REG_LOST,
                    m26_bus_pkg::m26_bus_data_t'(row.lost));
        check_flag({row.name, "_lost_error"}, row.lost != 0, lost_error);
    endtask

    initial begin
        seed      = 24181;
        driving   = 1'b0;
        mkd_rx    = 1'b0;
        data_rx   = 2'b00;
        bus_addr  = m26_bus_pkg::REG_CTRL;
        bus_wr    = 1'b0;
        bus_rd    = 1'b0;
        bus_wdata = '0;
        out_ready = 1'b1;

        // name, enable, length field, data words, hold ready low, lost count.
        rows[0] = '{"disabled",     1'b0, 2,  2,  1'b0, 0};
        rows[1] = '{"basic",        1'b1, 3,  3,  1'b0, 0};
        rows[2] = '{"no_data",      1'b1, 0,  0,  1'b0, 0};
        rows[3] = '{"too_long",     1'b1, 12, 12, 1'b0, 0};
        rows[4] = '{"after_long",   1'b1, 8,  8,  1'b0, 0};
        rows[5] = '{"backpressure", 1'b1, 8,  8,  1'b1, 10};

        wait_reset();
        read_expect("reset_version", m26_bus_pkg::REG_CTRL, `M26_VERSION);
        read_expect("reset_enable", m26_bus_pkg::REG_ENABLE, 8'h00);
        read_expect("reset_lost", m26_bus_pkg::REG_LOST, 8'h00);
        check_flag("reset_lost_error", 1'b0, lost_error);

        for (int r = 0; r < 6; r++) begin
            run_row(rows[r]);
        end

        // soft reset clears the counter and the enable bit.
        bus_write(m26_bus_pkg::REG_CTRL, 8'h00);
        read_expect("soft_rst_lost", m26_bus_pkg::REG_LOST, 8'h00);
        check_flag("soft_rst_lost_error", 1'b0, lost_error);
        read_expect("soft_rst_enable", m26_bus_pkg::REG_ENABLE, 8'h00);

        $display("sim passed");
        $finish;
    end

endmodule

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen (
    output logic CLK_RX,
    output logic RST
);

    // 8 ns period.
    initial begin
        CLK_RX = 1'b0;
        forever begin
            #4 CLK_RX = ~CLK_RX;
        end
    end

    // reset spans two rising edges, released on a falling edge.
    initial begin
        RST = 1'b1;
        repeat (2) @(posedge CLK_RX);
        @(negedge CLK_RX);
        RST = 1'b0;
    end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/m26_frame_pkg.sv
rtl/m26_bus_pkg.sv
rtl/m26_rx_ch.sv
rtl/m26_rx_regs.sv
rtl/m26_rx_fifo.sv
rtl/m26_rx_core.sv
sim/tb_clk_gen.sv
sim/m26_rx_tb.sv
